// ==== fetch_top.f ====
src/core_pkg.sv
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/fetch_addr_queue.sv
src/fetch_stage_out.sv
src/fetch_top.sv
sim/tb_clock_gen.sv
sim/tb_fetch_top.sv

// ==== Makefile ====
# Verilator simulation of the fetch front end

VERILATOR ?= verilator
TOP ?= tb_fetch_top
FLIST ?= fetch_top.f
ARGS ?=
BUILD ?= obj_dir

.PHONY: sim clean

# Build, run, and pass only when the pass line shows up
sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) $(ARGS)
	out=$$(./$(BUILD)/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(BUILD)

// ==== sim/tb_fetch_top.sv ====
module tb_fetch_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 4000; // About twice the total test length
	localparam logic [31:0] FAULT_ADDR = 32'h0000_0024; // Only page that faults

	// One request seen by the memory model
	typedef struct packed {
		logic [31:0] addr;
		logic paging_ena; // Mode at request time
		logic kernel_access;
		logic [31:0] due; // Cycle of the answer
	} pending_t;

	logic iCLOCK;
	logic inRESET;
	logic [31:0] sysreg_psr = 32'h0;
	logic exception_event = 1'b0;
	logic exception_addr_set = 1'b0;
	logic [31:0] exception_addr = 32'h0;
	logic fetch_lock = 1'b0;
	logic fetch_stop = 1'b0;
	logic next_lock = 1'b0;
	fetch_pkg::mem_resp_t mem_resp = '0;
	logic fetch_req;
	logic [31:0] fetch_addr;
	logic [1:0] mmumod;
	logic prev_lock;
	fetch_pkg::fetch_out_t next_out;

	pending_t pending [$]; // Requests not yet answered
	fetch_pkg::fetch_out_t resp_exp = '0; // Expected output for the response on the bus
	fetch_pkg::fetch_out_t out_exp = '0; // Expected next_out in this cycle
	fetch_pkg::fetch_out_t prev_out = '0;
	logic [31:0] exp_addr = 32'h0; // Next address fetch must issue
	logic [31:0] prev_addr = 32'h0;
	logic addr_held = 1'b0;
	logic was_locked = 1'b0;
	logic flushed = 1'b0;
	logic waiting = 1'b0; // Between flush and redirect
	logic draining = 1'b0;
	logic queue_full_exp = 1'b0; // Address queue holds a full set of entries
	int unsigned outstanding = 0;
	int unsigned lock_run = 0;
	int unsigned cycle = 0;
	// Reach counters for the checks
	int unsigned n_resp = 0;
	int unsigned n_predict = 0;
	int unsigned n_fault = 0;
	int unsigned n_full = 0;
	int unsigned n_lock_hold = 0;
	int unsigned n_redirect = 0;

	tb_clock_gen u_clock_gen (
		.iCLOCK (iCLOCK),
		.inRESET (inRESET)
	);

	fetch_top UUT (
		.iCLOCK (iCLOCK),
		.inRESET (inRESET),
		.sysreg_psr (sysreg_psr),
		.exception_event (exception_event),
		.exception_addr_set (exception_addr_set),
		.exception_addr (exception_addr),
		.fetch_req (fetch_req),
		.fetch_addr (fetch_addr),
		.mmumod (mmumod),
		.fetch_lock (fetch_lock),
		.prev_lock (prev_lock),
		.mem_resp (mem_resp),
		.next_out (next_out),
		.next_lock (next_lock),
		.fetch_stop (fetch_stop)
	);

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string test, input logic [127:0] exp,
			input logic [127:0] act);
		stop_on_error($sformatf("MISMATCH %s expected %0h actual %0h", test, exp, act));
	endtask

	// Every fourth word a branch, the rest the inverted address
	function automatic logic [31:0] inst_word_for(input logic [31:0] addr);
		logic [15:0] mag;
		logic [15:0] disp;
		logic [9:0] opc;
		logic [31:0] rot;
		mag = {10'h0, addr[7:2]} + 16'd1;
		disp = addr[4] ? mag : (~mag + 16'd1); // Sign alternates per branch
		rot = 32'(addr[31:4]) % 32'd3; // Branch opcode in rotation
		case (rot)
			32'd0: opc = core_pkg::OC_B;
			32'd1: opc = core_pkg::OC_BR;
			default: opc = core_pkg::OC_BUR;
		endcase
		if (addr[3:2] != 2'b11) begin
			return ~addr;
		end
		return {1'b0, opc, addr[8:4], disp};
	endfunction

	// What decode should see for one answered request
	function automatic fetch_pkg::fetch_out_t expected_output(input pending_t ent);
		fetch_pkg::fetch_out_t e;
		logic [15:0] mag;
		logic backward;
		mag = {10'h0, ent.addr[7:2]} + 16'd1;
		backward = (ent.addr[3:2] == 2'b11) && !ent.addr[4]; // Branch going back
		e = '0;
		e.valid = 1'b1;
		e.pagefault = (ent.addr == FAULT_ADDR);
		e.mmu_flags = ent.addr[15:2] ^ 14'h2a5;
		e.paging_ena = ent.paging_ena;
		e.kernel_access = ent.kernel_access;
		e.branch_predict = backward;
		e.branch_predict_addr = backward ? ent.addr - {14'h0, mag, 2'b00} : 32'h0;
		e.inst = inst_word_for(ent.addr);
		e.pc = ent.addr + 32'h4;
		return e;
	endfunction

	// Memory model, random back-pressure and PSR changes
	always @(posedge iCLOCK) begin
		pending_t ent;
		fetch_pkg::fetch_out_t e;
		logic lock_now;
		int unsigned level;
		if (!inRESET) begin
			pending.delete();
			queue_full_exp <= 1'b0;
		end
		else begin
			cycle++;
			if (cycle >= TIMEOUT_CYCLES) begin
				stop_on_error("Timeout: tests did not finish within the cycle limit");
			end
			if (draining) begin
				lock_now = 1'b0;
				lock_run = 0;
			end
			else if (lock_run > 0) begin
				lock_now = 1'b1; // Decode lock runs for several cycles
				lock_run--;
			end
			else if ($urandom % 12 == 0) begin
				lock_now = 1'b1;
				lock_run = 3 + $urandom % 12;
			end
			else begin
				lock_now = 1'b0;
			end
			next_lock <= lock_now;
			fetch_lock <= !draining && ($urandom % 8 == 0);
			fetch_stop <= draining || ($urandom % 10 == 0);
			if ($urandom % 50 == 0) begin
				sysreg_psr <= {25'h0, 2'($urandom), 3'h0, 2'($urandom)}; // Priv and MMU mode
			end
			if (exception_event) begin
				pending.delete(); // In-flight answers die with the flush
				mem_resp <= '0;
				resp_exp <= '0;
				queue_full_exp <= 1'b0;
			end
			else begin
				if (fetch_req) begin
					ent.addr = fetch_addr;
					ent.paging_ena = (sysreg_psr[1:0] != 2'b00);
					ent.kernel_access = (sysreg_psr[6:5] == 2'b00);
					ent.due = cycle + 1 + $urandom % 4; // 1 to 4 cycles latency
					pending.push_back(ent);
				end
				// DUT queue level after this edge, an answer sent now pops there later
				level = pending.size();
				if (!lock_now && pending.size() > 0 && pending[0].due <= cycle) begin
					e = expected_output(pending.pop_front());
					mem_resp <= {e.valid, e.pagefault, e.mmu_flags, e.inst};
					resp_exp <= e;
					n_resp++;
					if (e.branch_predict) n_predict++;
					if (e.pagefault) n_fault++;
				end
				else begin
					mem_resp <= '0;
					resp_exp <= '0;
				end
				queue_full_exp <= (level >= fetch_pkg::FETCH_QUEUE_DEPTH);
				if (level >= fetch_pkg::FETCH_QUEUE_DEPTH) n_full++;
			end
			outstanding <= pending.size();
		end
	end

	// Expected next_out, fetch address and flush state
	always @(posedge iCLOCK) begin
		if (!inRESET) begin
			out_exp <= '0;
			exp_addr <= 32'h0; // Fetch starts at zero
			waiting <= 1'b0;
			was_locked <= 1'b0;
			addr_held <= 1'b0;
			flushed <= 1'b0;
		end
		else begin
			if (exception_event) out_exp <= '0;
			else if (!next_lock) out_exp <= resp_exp;
			if (exception_addr_set) begin
				exp_addr <= {exception_addr[31:2], 2'b00};
				waiting <= 1'b0;
			end
			else begin
				if (fetch_req) exp_addr <= exp_addr + 32'h4;
				if (exception_event) waiting <= 1'b1;
			end
			if (was_locked && next_out.valid) n_lock_hold++;
			prev_out <= next_out;
			was_locked <= next_lock && !exception_event;
			prev_addr <= fetch_addr;
			addr_held <= !fetch_req && !exception_addr_set;
			flushed <= exception_event;
		end
	end

	a_fetch_addr: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		fetch_req |-> fetch_addr == exp_addr)
		else report_mismatch("fetch address", 128'($sampled(exp_addr)),
			128'($sampled(fetch_addr)));
	a_addr_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		addr_held |-> fetch_addr == prev_addr)
		else report_mismatch("address hold", 128'($sampled(prev_addr)),
			128'($sampled(fetch_addr)));
	a_req_gate: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(fetch_lock || fetch_stop || queue_full_exp) |-> !fetch_req)
		else report_mismatch("request gating", 128'(0), 128'($sampled(fetch_req)));
	a_out_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next_out.valid == out_exp.valid)
		else report_mismatch("output valid", 128'($sampled(out_exp.valid)),
			128'($sampled(next_out.valid)));
	a_out_inst: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		out_exp.valid |-> next_out.inst == out_exp.inst)
		else report_mismatch("in-order inst", 128'($sampled(out_exp.inst)),
			128'($sampled(next_out.inst)));
	a_out_pc: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		out_exp.valid |-> next_out.pc == out_exp.pc)
		else report_mismatch("in-order pc", 128'($sampled(out_exp.pc)),
			128'($sampled(next_out.pc)));
	a_out_mem_flags: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		out_exp.valid |-> {next_out.pagefault, next_out.mmu_flags}
			== {out_exp.pagefault, out_exp.mmu_flags})
		else report_mismatch("pagefault and mmu flags",
			128'($sampled({out_exp.pagefault, out_exp.mmu_flags})),
			128'($sampled({next_out.pagefault, next_out.mmu_flags})));
	a_out_mode: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		out_exp.valid |-> {next_out.paging_ena, next_out.kernel_access}
			== {out_exp.paging_ena, out_exp.kernel_access})
		else report_mismatch("mode at request",
			128'($sampled({out_exp.paging_ena, out_exp.kernel_access})),
			128'($sampled({next_out.paging_ena, next_out.kernel_access})));
	a_predict: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		out_exp.valid |-> {next_out.branch_predict, next_out.branch_predict_addr}
			== {out_exp.branch_predict, out_exp.branch_predict_addr})
		else report_mismatch("static prediction",
			128'($sampled({out_exp.branch_predict, out_exp.branch_predict_addr})),
			128'($sampled({next_out.branch_predict, next_out.branch_predict_addr})));
	a_lock_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		was_locked |-> next_out == prev_out)
		else report_mismatch("decode lock hold", 128'($sampled(prev_out)),
			128'($sampled(next_out)));
	a_prev_lock: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		prev_lock == next_lock)
		else report_mismatch("prev_lock", 128'($sampled(next_lock)),
			128'($sampled(prev_lock)));
	a_mmumod: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mmumod == sysreg_psr[1:0])
		else report_mismatch("mmumod", 128'($sampled(sysreg_psr[1:0])),
			128'($sampled(mmumod)));
	a_flush_out: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		flushed |-> !next_out.valid)
		else report_mismatch("flush output", 128'(0), 128'($sampled(next_out.valid)));
	a_flush_idle: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(exception_event || waiting) |-> !fetch_req)
		else report_mismatch("idle until redirect", 128'(0), 128'($sampled(fetch_req)));

	task automatic wait_for_request();
		do @(posedge iCLOCK); while (!fetch_req);
	endtask

	// Flush, idle gap, then load a new PC
	task automatic redirect(input logic [31:0] target, input int unsigned gap);
		exception_event <= 1'b1;
		@(posedge iCLOCK);
		exception_event <= 1'b0;
		repeat (gap) @(posedge iCLOCK);
		exception_addr <= target;
		exception_addr_set <= 1'b1;
		@(posedge iCLOCK);
		exception_addr_set <= 1'b0;
		wait_for_request(); // First fetch at the new PC
		n_redirect++;
	endtask

	task automatic drain_outstanding();
		draining <= 1'b1; // Stop fetching, no decode lock
		do @(posedge iCLOCK); while (outstanding != 0);
		repeat (3) @(posedge iCLOCK);
	endtask

	initial begin
		void'($urandom(32'ha46d));
		wait (inRESET === 1'b1);
		@(posedge iCLOCK);
		repeat (800) @(posedge iCLOCK); // Sequential fetch from zero
		redirect(32'h0001_2343, 3);
		repeat (300) @(posedge iCLOCK);
		redirect(32'h0000_0803, 6);
		repeat (300) @(posedge iCLOCK);
		redirect(32'h00a0_0002, 4);
		repeat (300) @(posedge iCLOCK);
		redirect(32'h0000_4001, 7);
		repeat (300) @(posedge iCLOCK);
		drain_outstanding();
		if (n_resp == 0 || n_predict == 0 || n_fault == 0 || n_full == 0
				|| n_lock_hold == 0 || n_redirect != 4) begin
			stop_on_error($sformatf({"Stimulus missed a check: responses %0d predicted %0d ",
				"faults %0d full %0d lock holds %0d redirects %0d"},
				n_resp, n_predict, n_fault, n_full, n_lock_hold, n_redirect));
		end
		else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

// ==== sim/tb_clock_gen.sv ====
module tb_clock_gen (
	output logic iCLOCK,
	output logic inRESET
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 8;

	initial begin
		iCLOCK = 1'b0;
		forever #10 iCLOCK = ~iCLOCK; // 20 ns period
	end

	// Reset held low, released on a rising edge
	initial begin
		inRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		inRESET <= 1'b1;
	end

endmodule

// ==== src/fetch_top.sv ====
module fetch_top (
	input logic iCLOCK,
	input logic inRESET,
	// System
	input logic [31:0] sysreg_psr,
	input logic exception_event,
	input logic exception_addr_set,
	input logic [31:0] exception_addr,
	// Memory side
	output logic fetch_req,
	output logic [31:0] fetch_addr,
	output logic [1:0] mmumod,
	input logic fetch_lock,
	output logic prev_lock,
	input fetch_pkg::mem_resp_t mem_resp,
	// Decode side
	output fetch_pkg::fetch_out_t next_out,
	input logic next_lock,
	input logic fetch_stop
);

	logic queue_full;
	fetch_pkg::fetch_qentry_t req_entry; // Issued address and mode
	fetch_pkg::fetch_qentry_t queue_head; // Oldest outstanding entry

	assign fetch_addr = req_entry.addr;
	assign mmumod = sysreg_psr[core_pkg::PSR_MMUMOD_LSB +: 2];
	assign prev_lock = next_lock; // Memory pipeline stalls with decode

	fetch_pc_gen u_pc_gen (
		.iCLOCK (iCLOCK),
		.inRESET (inRESET),
		.sysreg_psr (sysreg_psr),
		.exception_event (exception_event),
		.exception_addr_set (exception_addr_set),
		.exception_addr (exception_addr),
		.queue_full (queue_full),
		.fetch_lock (fetch_lock),
		.fetch_stop (fetch_stop),
		.fetch_req (fetch_req),
		.req_entry (req_entry)
	);

	// Push on request, pop on response
	fetch_addr_queue u_addr_queue (
		.iCLOCK (iCLOCK),
		.inRESET (inRESET),
		.flush (exception_event),
		.wr_en (fetch_req),
		.wr_entry (req_entry),
		.full (queue_full),
		.rd_en (mem_resp.valid),
		.head (queue_head)
	);

	fetch_stage_out u_stage_out (
		.iCLOCK (iCLOCK),
		.inRESET (inRESET),
		.flush (exception_event),
		.hold (next_lock),
		.resp (mem_resp),
		.head (queue_head),
		.out (next_out)
	);

endmodule

// ==== src/fetch_stage_out.sv ====
module fetch_stage_out (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush, // Clear output on exception
	input logic hold, // Decode lock
	// Memory response and its queued address
	input fetch_pkg::mem_resp_t resp,
	input fetch_pkg::fetch_qentry_t head,
	// To decode
	output fetch_pkg::fetch_out_t out
);

	fetch_pkg::fetch_out_t out_q;
	logic is_branch; // Opcode is one of the branches
	logic predict; // Backward taken
	logic [31:0] disp_ext; // Byte offset of branch target
	logic [31:0] target;

	// Opcode check through the general view
	always_comb begin
		case (resp.inst.gen.opcode)
			core_pkg::OC_B,
			core_pkg::OC_BR,
			core_pkg::OC_BUR: is_branch = 1'b1;
			default: is_branch = 1'b0;
		endcase
	end

	// Displacement through the branch view
	assign predict = is_branch && resp.inst.br.disp[15]; // Negative means loop
	assign disp_ext = {{14{resp.inst.br.disp[15]}}, resp.inst.br.disp, 2'b00};
	assign target = head.addr + disp_ext;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			out_q <= '0;
		end
		else if (flush) begin
			out_q <= '0; // Drop whatever was in flight
		end
		else if (!hold) begin
			// Memory side flags
			out_q.valid <= resp.valid;
			out_q.pagefault <= resp.pagefault;
			out_q.mmu_flags <= resp.mmu_flags;
			// Mode at issue time
			out_q.paging_ena <= head.paging_ena;
			out_q.kernel_access <= head.kernel_access;
			// Static prediction
			out_q.branch_predict <= predict;
			out_q.branch_predict_addr <= predict ? target : 32'h0;
			// Instruction and its PC
			out_q.inst <= resp.inst;
			out_q.pc <= head.addr + 32'h4;
		end
	end

	assign out = out_q;

	// Memory side keeps quiet while decode is locked
	a_no_resp_on_hold: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		resp.valid |-> !hold
	) else $error("fetch_stage_out: response strobe during decode lock");

endmodule

// ==== src/fetch_addr_queue.sv ====
module fetch_addr_queue (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush, // Drop all entries
	// Write side, from PC generator
	input logic wr_en,
	input fetch_pkg::fetch_qentry_t wr_entry,
	output logic full,
	// Read side, popped by memory response
	input logic rd_en,
	output fetch_pkg::fetch_qentry_t head
);

	// Entry storage
	fetch_pkg::fetch_qentry_t mem [fetch_pkg::FETCH_QUEUE_DEPTH];

	logic [fetch_pkg::FETCH_QUEUE_AW-1:0] wr_ptr;
	logic [fetch_pkg::FETCH_QUEUE_AW-1:0] rd_ptr;
	logic [fetch_pkg::FETCH_QUEUE_AW:0] count; // One extra bit for full
	logic empty;

	// Depth is a power of two so the top count bit means full
	assign full = count[fetch_pkg::FETCH_QUEUE_AW];
	assign empty = (count == '0);

	// Oldest entry, which a read pops in the same cycle
	assign head = mem[rd_ptr];

	// Storage write
	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_entry;
		end
	end

	// Pointers and count
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else if (flush) begin
			// Exception empties the queue
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	// PC generator must respect full
	a_no_overflow: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		wr_en |-> (!full || rd_en)
	) else $error("fetch_addr_queue: write while full");

	// Memory must not answer a request it never got
	a_no_underflow: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		(rd_en && !flush) |-> !empty
	) else $error("fetch_addr_queue: read while empty");

endmodule

// ==== src/fetch_pc_gen.sv ====
module fetch_pc_gen (
	input logic iCLOCK,
	input logic inRESET,
	// System register
	input logic [31:0] sysreg_psr,
	// Exception control
	input logic exception_event,
	input logic exception_addr_set,
	input logic [31:0] exception_addr,
	// Back-pressure
	input logic queue_full,
	input logic fetch_lock,
	input logic fetch_stop,
	// Request out
	output logic fetch_req,
	output fetch_pkg::fetch_qentry_t req_entry
);

	logic [31:0] pc; // Next address to issue
	logic fetch_valid; // PC holds a usable address
	logic [1:0] state;
	logic paging_ena;
	logic kernel_access;

	// Mode flags sampled from the live PSR
	assign paging_ena = |sysreg_psr[core_pkg::PSR_MMUMOD_LSB +: 2];
	assign kernel_access = (sysreg_psr[core_pkg::PSR_PRIV_LSB +: 2] == 2'b00);

	// Request only when nothing blocks
	assign fetch_req = fetch_valid
		&& !exception_event // Drop at once on flush
		&& !fetch_lock
		&& !fetch_stop
		&& !queue_full;

	// Stamp request with its mode
	assign req_entry.addr = pc;
	assign req_entry.paging_ena = paging_ena;
	assign req_entry.kernel_access = kernel_access;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pc <= 32'h0;
			fetch_valid <= 1'b0;
			state <= fetch_pkg::FETCH_ST_RESET;
		end
		else if (exception_addr_set) begin
			// Redirect wins over everything
			pc <= {exception_addr[31:2], 2'b00};
			fetch_valid <= 1'b1;
			state <= fetch_pkg::FETCH_ST_RUN;
		end
		else if (exception_event) begin
			fetch_valid <= 1'b0; // Idle until redirect
			state <= fetch_pkg::FETCH_ST_WAIT;
		end
		else begin
			case (state)
				fetch_pkg::FETCH_ST_RESET: begin
					// Start at address zero
					pc <= 32'h0;
					fetch_valid <= 1'b1;
					state <= fetch_pkg::FETCH_ST_RUN;
				end
				fetch_pkg::FETCH_ST_RUN: begin
					if (fetch_req) begin
						pc <= pc + 32'h4; // Sequential fetch
					end
				end
				fetch_pkg::FETCH_ST_WAIT: begin
					fetch_valid <= 1'b0; // Hold PC
				end
				default: begin
					fetch_valid <= 1'b0;
					state <= fetch_pkg::FETCH_ST_WAIT;
				end
			endcase
		end
	end

	// Every issued address lands on a word boundary
	a_pc_aligned: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		pc[1:0] == 2'b00
	) else $error("fetch_pc_gen: unaligned PC %h", pc);

endmodule

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

	// Address queue geometry
	localparam int FETCH_QUEUE_DEPTH = 8; // Power of two
	localparam int FETCH_QUEUE_AW = 3; // log2 of depth

	// PC generator states
	localparam logic [1:0] FETCH_ST_RESET = 2'd0; // First cycle after reset
	localparam logic [1:0] FETCH_ST_RUN = 2'd1; // Issuing requests
	localparam logic [1:0] FETCH_ST_WAIT = 2'd2; // Flushed, waiting for new PC

	// One outstanding fetch
	typedef struct packed {
		logic [31:0] addr; // Word aligned fetch address
		logic paging_ena; // MMU mode nonzero at issue
		logic kernel_access; // Privilege zero at issue
	} fetch_qentry_t;

	// Response from instruction memory
	typedef struct packed {
		logic valid; // One cycle strobe
		logic pagefault;
		logic [13:0] mmu_flags;
		core_pkg::inst_word_u inst;
	} mem_resp_t;

	// Instruction handed to decode
	typedef struct packed {
		logic valid;
		logic pagefault;
		logic [13:0] mmu_flags;
		logic paging_ena;
		logic kernel_access;
		logic branch_predict; // Backward branch, assumed taken
		logic [31:0] branch_predict_addr; // Target or zero
		logic [31:0] inst;
		logic [31:0] pc; // Fetch address plus 4
	} fetch_out_t;

endpackage

// ==== src/core_pkg.sv ====
package core_pkg;

	// General decode view of an instruction word
	typedef struct packed {
		logic spare; // Top bit, reserved
		logic [9:0] opcode; // Major opcode in bits 30:21
		logic [20:0] operand; // Register and immediate fields
	} inst_gen_t;

	// Branch decode view of the same word
	typedef struct packed {
		logic spare;
		logic [9:0] opcode;
		logic [4:0] cond; // Condition code
		logic signed [15:0] disp; // Displacement in words
	} inst_branch_t;

	// One word, two decodes
	typedef union packed {
		inst_gen_t gen;
		inst_branch_t br;
	} inst_word_u;

	// Branch opcodes
	localparam logic [9:0] OC_B = 10'h104; // Branch on condition
	localparam logic [9:0] OC_BR = 10'h105; // Branch via register
	localparam logic [9:0] OC_BUR = 10'h106; // Unconditional relative

	// PSR field positions
	localparam int PSR_MMUMOD_LSB = 0; // MMU mode, 2 bits
	localparam int PSR_PRIV_LSB = 5; // Privilege level, 2 bits

endpackage
